// ==== flist.f ====
hdl/MemStagePkg.sv
hdl/DataMemoryBus.sv
hdl/LoadStoreAligner.sv
hdl/StageMEM.sv
hdl/DataBusAxiMaster.sv
hdl/MemStageControl.sv
hdl/MemStageTop.sv
verification/MemStageChecker.sv
verification/MemStageTb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f flist.f --top-module MemStageTb -o simv &&
./obj_dir/simv | tee /dev/stderr | grep -qx "TEST PASS" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// ==== verification/MemStageTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module MemStageTb import MemStagePkg::*; ();

    localparam int NUM_RANDOM = 400;
    localparam int NUM_OPS    = NUM_RANDOM + 40;

    logic                  i_Clock = 1'b0;
    logic                  i_rstN;
    logic                  i_ExValid;
    logic                  o_ExReady;
    logic [PC_WIDTH-1:0]   i_ExPc;
    logic [DATA_WIDTH-1:0] i_ExResult;
    logic [DATA_WIDTH-1:0] i_ExDataB;
    logic                  i_ExMemWrite;
    MemSize_t              i_ExMemSize;
    RegWrSel_t             i_ExRegWrDataSel;
    logic                  i_ExRegWrite;
    logic [REG_WIDTH-1:0]  i_ExRd;
    logic                  o_WbValid;
    logic [REG_WIDTH-1:0]  o_WbRd;
    logic [DATA_WIDTH-1:0] o_WbData;
    logic                  o_AwValid;
    logic                  i_AwReady;
    logic                  o_WValid;
    logic                  i_WReady;
    logic                  i_BValid;
    logic                  o_BReady;
    logic                  o_ArValid;
    logic                  i_ArReady;
    logic                  i_RValid;
    logic                  o_RReady;
    logic [ADDR_WIDTH-1:0] o_AwAddr;
    logic [ADDR_WIDTH-1:0] o_ArAddr;
    logic [DATA_WIDTH-1:0] o_WData;
    logic [DATA_WIDTH-1:0] i_RData;
    logic [3:0]            o_WStrb;
    logic [7:0]            Mem [256];
    int                    ValueErrors;
    int                    OtherErrors;
    int                    Pending;
    int                    LocalErrors = 0;

    always #2 i_Clock = ~i_Clock;

    MemStageTop u_dut (.*);

    MemStageChecker u_check (
        .i_Clock (i_Clock), .i_rstN (i_rstN), .i_ExValid (i_ExValid),
        .i_ExReady (o_ExReady), .i_ExPc (i_ExPc), .i_ExResult (i_ExResult),
        .i_ExDataB (i_ExDataB), .i_ExMemWrite (i_ExMemWrite), .i_ExMemSize (i_ExMemSize),
        .i_ExRegWrDataSel (i_ExRegWrDataSel), .i_ExRegWrite (i_ExRegWrite),
        .i_ExRd (i_ExRd), .i_WbValid (o_WbValid), .i_WbRd (o_WbRd), .i_WbData (o_WbData),
        .o_ValueErrors (ValueErrors), .o_OtherErrors (OtherErrors), .o_Pending (Pending));

    // Watchdog allows 20 cycles per operation
    initial begin
        #(NUM_OPS * 20 * 4);
        $display("Timeout, the DUT stopped making progress");
        $display("TEST FAIL");
        $finish;
    end

    // ----------------------------------------------------------
    // AXI4-Lite memory model
    // ----------------------------------------------------------

    // Wait 0 to 3 cycles and end 1 ns after a rising edge
    task automatic RandomDelay();
        repeat ($urandom % 4) begin
            @(posedge i_Clock);
            #1;
        end
    endtask

    task automatic ServeWrite();
        logic [7:0]  addr;
        logic [31:0] data;
        logic [3:0]  strb;
        RandomDelay();
        i_AwReady = 1'b1;
        i_WReady  = 1'b1;
        addr      = o_AwAddr[7:0];
        data      = o_WData;
        strb      = o_WStrb;
        @(posedge i_Clock);
        #1;
        i_AwReady = 1'b0;
        i_WReady  = 1'b0;
        for (int k = 0; k < 4; k++) begin
            if (strb[k]) begin
                Mem[{addr[7:2], 2'(k)}] = data[8*k +: 8];
            end
        end
        RandomDelay();
        i_BValid = 1'b1;
        while (!o_BReady) begin
            @(posedge i_Clock);
            #1;
        end
        @(posedge i_Clock);
        #1;
        i_BValid = 1'b0;
    endtask

    task automatic ServeRead();
        logic [7:0] addr;
        RandomDelay();
        i_ArReady = 1'b1;
        addr      = {o_ArAddr[7:2], 2'b00};
        @(posedge i_Clock);
        #1;
        i_ArReady = 1'b0;
        RandomDelay();
        i_RData  = {Mem[addr + 8'd3], Mem[addr + 8'd2], Mem[addr + 8'd1], Mem[addr]};
        i_RValid = 1'b1;
        while (!o_RReady) begin
            @(posedge i_Clock);
            #1;
        end
        @(posedge i_Clock);
        #1;
        i_RValid = 1'b0;
    endtask

    initial begin
        for (int a = 0; a < 256; a++) begin
            Mem[a] = 8'((a * 37) ^ 8'hc3);
        end
        forever begin
            @(posedge i_Clock);
            #1;
            if (o_AwValid) begin
                ServeWrite();
            end else if (o_ArValid) begin
                ServeRead();
            end
        end
    end

    // ----------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------

    // Hold the instruction until the accept edge
    task automatic Issue(string name, logic [31:0] pc, logic [31:0] result,
        logic [31:0] dataB, logic memWrite, MemSize_t size, RegWrSel_t sel,
        logic regWrite, logic [4:0] rd);
        u_check.TestName = name;
        i_ExPc           = pc;
        i_ExResult       = result;
        i_ExDataB        = dataB;
        i_ExMemWrite     = memWrite;
        i_ExMemSize      = size;
        i_ExRegWrDataSel = sel;
        i_ExRegWrite     = regWrite;
        i_ExRd           = rd;
        i_ExValid        = 1'b1;
        while (!o_ExReady) begin
            @(posedge i_Clock);
            #1;
        end
        @(posedge i_Clock);
        #1;
        i_ExValid = 1'b0;
    endtask

    initial begin
        MemSize_t    sizes [5];
        MemSize_t    size;
        logic [31:0] addr;
        int          kind;
        int          drainCycles;
        sizes = '{SizeByte, SizeHalf, SizeWord, SizeByteU, SizeHalfU};
        void'($urandom(32'hb08f));
        i_rstN = 1'b0;
        i_ExValid = 1'b0;
        i_ExPc = '0;
        i_ExResult = '0;
        i_ExDataB = '0;
        i_ExMemWrite = 1'b0;
        i_ExMemSize = SizeWord;
        i_ExRegWrDataSel = SelAlu;
        i_ExRegWrite = 1'b0;
        i_ExRd = '0;
        i_AwReady = 1'b0;
        i_WReady = 1'b0;
        i_BValid = 1'b0;
        i_ArReady = 1'b0;
        i_RValid = 1'b0;
        i_RData = '0;
        repeat (4) @(posedge i_Clock);
        #1;
        i_rstN = 1'b1;
        @(posedge i_Clock);
        #1;

        // Idle state right after reset
        if (o_WbValid || o_AwValid || o_WValid || o_ArValid || o_BReady || o_RReady
            || !o_ExReady) begin
            LocalErrors++;
            $display("Outputs not in their idle state after reset");
        end

        Issue("alu", 32'h100, 32'h1234_5678, 32'h0, 1'b0, SizeWord, SelAlu, 1'b1, 5'd1);
        Issue("link", 32'h2000_0ff8, 32'h0, 32'h0, 1'b0, SizeWord, SelPcPlus4, 1'b1, 5'd2);
        Issue("word store", 32'h0, 32'h40, 32'hdead_beef, 1'b1, SizeWord, SelAlu, 1'b0, 5'd3);
        Issue("word load", 32'h0, 32'h40, 32'h0, 1'b0, SizeWord, SelMemData, 1'b1, 5'd7);

        // Every stored lane value has its top bit set so that extension shows
        for (int lane = 0; lane < 4; lane++) begin
            addr = 32'h80 + 32'(lane);
            Issue("byte store", 0, addr, 32'h80 | 32'(lane * 17), 1'b1, SizeByte, SelAlu,
                1'b0, 5'd0);
            Issue("byte load", 0, addr, 0, 1'b0, SizeByte, SelMemData, 1'b1, 5'd8);
            Issue("byteu load", 0, addr, 0, 1'b0, SizeByteU, SelMemData, 1'b1, 5'd9);
        end
        for (int h = 0; h < 2; h++) begin
            addr = 32'h90 + 32'(2 * h);
            Issue("half store", 0, addr, 32'h8000 | 32'(h * 32'h1234), 1'b1, SizeHalf,
                SelAlu, 1'b0, 5'd0);
            Issue("half load", 0, addr, 0, 1'b0, SizeHalf, SelMemData, 1'b1, 5'd10);
            Issue("halfu load", 0, addr, 0, 1'b0, SizeHalfU, SelMemData, 1'b1, 5'd11);
        end

        // Random mix with addresses aligned to the access size
        for (int n = 0; n < NUM_RANDOM; n++) begin
            kind = $urandom % 4;
            size = sizes[$urandom % 5];
            addr = $urandom % 256;
            if (size == SizeWord) begin
                addr = addr & ~32'd3;
            end else if (size inside {SizeHalf, SizeHalfU}) begin
                addr = addr & ~32'd1;
            end
            case (kind)
                0: Issue("random alu", $urandom, $urandom, $urandom, 1'b0, size, SelAlu,
                    1'b1, 5'($urandom));
                1: Issue("random link", $urandom, $urandom, 0, 1'b0, size, SelPcPlus4,
                    1'b1, 5'($urandom));
                2: Issue("random store", 0, addr, $urandom, 1'b1, size, SelAlu,
                    1'($urandom), 5'($urandom));
                default: Issue("random load", 0, addr, 0, 1'b0, size, SelMemData,
                    1'b1, 5'($urandom));
            endcase
        end

        // Drain the last access within 40 cycles
        drainCycles = 0;
        while (!(o_ExReady && Pending == 0) && drainCycles < 40) begin
            @(posedge i_Clock);
            #1;
            drainCycles++;
        end
        repeat (5) @(posedge i_Clock);
        #1;
        if (Pending != 0) begin
            LocalErrors++;
            $display("Write-backs missing at the end of the run");
        end
        if (!o_ExReady) begin
            LocalErrors++;
            $display("DUT still busy with an access at the end of the run");
        end

        $display("Errors: %0d value, %0d other", ValueErrors, OtherErrors + LocalErrors);
        if (ValueErrors + OtherErrors + LocalErrors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/MemStageChecker.sv ====
`timescale 1ns/1ns
`default_nettype none

module MemStageChecker import MemStagePkg::*; (
    input  logic                  i_Clock,
    input  logic                  i_rstN,
    input  logic                  i_ExValid,
    input  logic                  i_ExReady,
    input  logic [PC_WIDTH-1:0]   i_ExPc,
    input  logic [DATA_WIDTH-1:0] i_ExResult,
    input  logic [DATA_WIDTH-1:0] i_ExDataB,
    input  logic                  i_ExMemWrite,
    input  MemSize_t              i_ExMemSize,
    input  RegWrSel_t             i_ExRegWrDataSel,
    input  logic                  i_ExRegWrite,
    input  logic [REG_WIDTH-1:0]  i_ExRd,
    input  logic                  i_WbValid,
    input  logic [REG_WIDTH-1:0]  i_WbRd,
    input  logic [DATA_WIDTH-1:0] i_WbData,
    output int                    o_ValueErrors,
    output int                    o_OtherErrors,
    output int                    o_Pending
);

    // Shadow of the 256-byte memory, 64 words
    MemWord_u              Shadow [64];
    logic [REG_WIDTH-1:0]  ExpRd [$];
    logic [DATA_WIDTH-1:0] ExpData [$];
    string                 ExpName [$];
    string                 TestName = "none";
    int                    ValueErrors = 0;
    int                    OtherErrors = 0;
    int                    PendingCount = 0;

    assign o_ValueErrors = ValueErrors;
    assign o_OtherErrors = OtherErrors;
    assign o_Pending     = PendingCount;

    // Same fill rule as the memory model, depends on all 8 address bits
    initial begin
        for (int a = 0; a < 256; a++) begin
            Shadow[a / 4].Bytes[a % 4] = 8'((a * 37) ^ 8'hc3);
        end
    end

    // ----------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------

    function automatic logic [DATA_WIDTH-1:0] ExpectedWb(
        RegWrSel_t sel, logic [PC_WIDTH-1:0] pc, logic [DATA_WIDTH-1:0] result,
        MemSize_t size);
        MemWord_u    word;
        logic [7:0]  lane8;
        logic [15:0] lane16;
        word   = Shadow[result[7:2]];
        lane8  = word.Bytes[result[1:0]];
        lane16 = word.Halves[result[1]];
        if (sel == SelPcPlus4) begin
            return pc + 32'd4;
        end else if (sel != SelMemData) begin
            return result;
        end
        // Loads, signed sizes copy the top bit of the lane
        case (size)
            SizeByte:  return {{24{lane8[7]}}, lane8};
            SizeByteU: return {24'd0, lane8};
            SizeHalf:  return {{16{lane16[15]}}, lane16};
            SizeHalfU: return {16'd0, lane16};
            default:   return word.Word;
        endcase
    endfunction

    task automatic ApplyStore(logic [DATA_WIDTH-1:0] addr, logic [DATA_WIDTH-1:0] data,
        MemSize_t size);
        case (size)
            SizeByte, SizeByteU: Shadow[addr[7:2]].Bytes[addr[1:0]] = data[7:0];
            SizeHalf, SizeHalfU: Shadow[addr[7:2]].Halves[addr[1]] = data[15:0];
            default:             Shadow[addr[7:2]].Word = data;
        endcase
    endtask

    // ----------------------------------------------------------
    // Compare at the falling edge, where all ports are settled
    // ----------------------------------------------------------

    always @(negedge i_Clock) begin
        if (i_rstN) begin
            // Write-back of an older instruction is checked first
            if (i_WbValid) begin
                if (ExpRd.size() == 0) begin
                    OtherErrors++;
                    $display("Extra write-back to x%0d with no instruction waiting", i_WbRd);
                end else begin
                    if (i_WbRd !== ExpRd[0]) begin
                        ValueErrors++;
                        $display("FAIL %s rd expected %0d actual %0d",
                            ExpName[0], ExpRd[0], i_WbRd);
                    end
                    if (i_WbData !== ExpData[0]) begin
                        ValueErrors++;
                        $display("FAIL %s data expected %08h actual %08h",
                            ExpName[0], ExpData[0], i_WbData);
                    end
                    void'(ExpRd.pop_front());
                    void'(ExpData.pop_front());
                    void'(ExpName.pop_front());
                end
            end
            // Accept happens at the next rising edge
            if (i_ExValid && i_ExReady) begin
                if (i_ExRegWrite) begin
                    ExpRd.push_back(i_ExRd);
                    ExpData.push_back(ExpectedWb(i_ExRegWrDataSel, i_ExPc, i_ExResult,
                        i_ExMemSize));
                    ExpName.push_back(TestName);
                end
                if (i_ExMemWrite) begin
                    ApplyStore(i_ExResult, i_ExDataB, i_ExMemSize);
                end
            end
            PendingCount = ExpRd.size();
        end
    end

endmodule

`default_nettype wire

// ==== hdl/MemStageTop.sv ====
`timescale 1ns/1ns
`default_nettype none

module MemStageTop import MemStagePkg::*; (
    input  logic                  i_Clock,
    input  logic                  i_rstN,

    // Execute stage
    input  logic                  i_ExValid,
    output logic                  o_ExReady,
    input  logic [PC_WIDTH-1:0]   i_ExPc,
    input  logic [DATA_WIDTH-1:0] i_ExResult,
    input  logic [DATA_WIDTH-1:0] i_ExDataB,
    input  logic                  i_ExMemWrite,
    input  MemSize_t              i_ExMemSize,
    input  RegWrSel_t             i_ExRegWrDataSel,
    input  logic                  i_ExRegWrite,
    input  logic [REG_WIDTH-1:0]  i_ExRd,

    // Register write-back
    output logic                  o_WbValid,
    output logic [REG_WIDTH-1:0]  o_WbRd,
    output logic [DATA_WIDTH-1:0] o_WbData,

    // AXI4-Lite data memory
    output logic                  o_AwValid,
    input  logic                  i_AwReady,
    output logic [ADDR_WIDTH-1:0] o_AwAddr,
    output logic                  o_WValid,
    input  logic                  i_WReady,
    output logic [DATA_WIDTH-1:0] o_WData,
    output logic [3:0]            o_WStrb,
    input  logic                  i_BValid,
    output logic                  o_BReady,
    output logic                  o_ArValid,
    input  logic                  i_ArReady,
    output logic [ADDR_WIDTH-1:0] o_ArAddr,
    input  logic                  i_RValid,
    output logic                  o_RReady,
    input  logic [DATA_WIDTH-1:0] i_RData
);

    logic      Hold;
    logic      WbLoad;
    RegWrSel_t HoldRegWrDataSel;

    DataMemoryBus DBus ();

    // Handshake, held control fields and sequencing
    MemStageControl Control (
        .i_Clock            (i_Clock),
        .i_rstN             (i_rstN),
        .i_ExValid          (i_ExValid),
        .i_ExRegWrite       (i_ExRegWrite),
        .i_ExRegWrDataSel   (i_ExRegWrDataSel),
        .i_ExRd             (i_ExRd),
        .Bus                (DBus.Sequencer),
        .o_ExReady          (o_ExReady),
        .o_Hold             (Hold),
        .o_HoldRegWrDataSel (HoldRegWrDataSel),
        .o_WbLoad           (WbLoad),
        .o_WbValid          (o_WbValid),
        .o_WbRd             (o_WbRd));

    // Address, store data and write-back value
    StageMEM Datapath (
        .i_Clock        (i_Clock),
        .i_rstN         (i_rstN),
        .i_Hold         (Hold),
        .i_Pc           (i_ExPc),
        .i_Result       (i_ExResult),
        .i_DataB        (i_ExDataB),
        .i_MemWrEnable  (i_ExMemWrite),
        .i_MemSize      (i_ExMemSize),
        .i_RegWrDataSel (HoldRegWrDataSel),
        .i_WbLoad       (WbLoad),
        .DBus           (DBus.Master),
        .o_RegWrData    (o_WbData));

    // Bus request to AXI4-Lite
    DataBusAxiMaster AxiMaster (
        .i_Clock   (i_Clock),
        .i_rstN    (i_rstN),
        .Bus       (DBus.Slave),
        .o_AwValid (o_AwValid),
        .i_AwReady (i_AwReady),
        .o_AwAddr  (o_AwAddr),
        .o_WValid  (o_WValid),
        .i_WReady  (i_WReady),
        .o_WData   (o_WData),
        .o_WStrb   (o_WStrb),
        .i_BValid  (i_BValid),
        .o_BReady  (o_BReady),
        .o_ArValid (o_ArValid),
        .i_ArReady (i_ArReady),
        .o_ArAddr  (o_ArAddr),
        .i_RValid  (i_RValid),
        .o_RReady  (o_RReady),
        .i_RData   (i_RData));

endmodule

`default_nettype wire

// ==== hdl/MemStageControl.sv ====
`timescale 1ns/1ns
`default_nettype none

module MemStageControl import MemStagePkg::*; (
    input  logic                 i_Clock,
    input  logic                 i_rstN,
    input  logic                 i_ExValid,
    input  logic                 i_ExRegWrite,
    input  RegWrSel_t            i_ExRegWrDataSel,
    input  logic [REG_WIDTH-1:0] i_ExRd,
    DataMemoryBus.Sequencer      Bus,
    output logic                 o_ExReady,
    output logic                 o_Hold,
    output RegWrSel_t            o_HoldRegWrDataSel,
    output logic                 o_WbLoad,
    output logic                 o_WbValid,
    output logic [REG_WIDTH-1:0] o_WbRd
);

    typedef enum logic [1:0] {
        StIdle,
        StAccess,
        StWriteBack
    } State_t;

    State_t    State;
    State_t    NextState;
    logic      Accept;
    logic      ReqPending;  // First cycle of an access
    logic      IsMem;
    logic      HoldRegWrite;
    RegWrSel_t HoldSel;

    // ----------------------------------------------------------
    // Execute handshake and held control fields
    // ----------------------------------------------------------

    // Free once the write-back register is loaded
    assign o_ExReady = State != StAccess;
    assign Accept    = i_ExValid && o_ExReady;
    assign o_Hold    = Accept;

    always_ff @(posedge i_Clock or negedge i_rstN) begin
        if (!i_rstN) begin
            HoldRegWrite <= 1'b0;
            HoldSel      <= SelAlu;
            ReqPending   <= 1'b0;
        end else begin
            ReqPending <= Accept;
            if (Accept) begin
                HoldRegWrite <= i_ExRegWrite;
                HoldSel      <= i_ExRegWrDataSel;
            end
        end
    end

    always_ff @(posedge i_Clock) begin
        if (Accept) begin
            o_WbRd <= i_ExRd;
        end
    end

    assign o_HoldRegWrDataSel = HoldSel;

    // ----------------------------------------------------------
    // Access sequencing
    // ----------------------------------------------------------

    // Load by select, store by the held write enable
    assign IsMem = (HoldSel == SelMemData) || Bus.WrEnable;

    assign Bus.Req = (State == StAccess) && ReqPending && IsMem;

    // Non-memory loads right away, memory on Done
    assign o_WbLoad = (State == StAccess) && ((ReqPending && !IsMem) || Bus.Done);

    // Write-back pulse, one cycle after the load
    assign o_WbValid = (State == StWriteBack) && HoldRegWrite;

    always_comb begin
        case (State)
            StIdle, StWriteBack: NextState = Accept ? StAccess : StIdle;
            StAccess:            NextState = o_WbLoad ? StWriteBack : StAccess;
            default:             NextState = StIdle;
        endcase
    end

    always_ff @(posedge i_Clock or negedge i_rstN) begin
        if (!i_rstN) begin
            State <= StIdle;
        end else begin
            State <= NextState;
        end
    end

    // Adapter ends only accesses that were started here
    assert property (@(posedge i_Clock) disable iff (!i_rstN)
        Bus.Done |-> State == StAccess && !ReqPending);

endmodule

`default_nettype wire

// ==== hdl/DataBusAxiMaster.sv ====
`timescale 1ns/1ns
`default_nettype none

module DataBusAxiMaster import MemStagePkg::*; (
    input  logic                  i_Clock,
    input  logic                  i_rstN,
    DataMemoryBus.Slave           Bus,

    // Write address and write data
    output logic                  o_AwValid,
    input  logic                  i_AwReady,
    output logic [ADDR_WIDTH-1:0] o_AwAddr,
    output logic                  o_WValid,
    input  logic                  i_WReady,
    output logic [DATA_WIDTH-1:0] o_WData,
    output logic [3:0]            o_WStrb,

    // Write response
    input  logic                  i_BValid,
    output logic                  o_BReady,

    // Read address and read data
    output logic                  o_ArValid,
    input  logic                  i_ArReady,
    output logic [ADDR_WIDTH-1:0] o_ArAddr,
    input  logic                  i_RValid,
    output logic                  o_RReady,
    input  logic [DATA_WIDTH-1:0] i_RData
);

    logic AwFinish;
    logic WFinish;

    // Bus holds these stable until Done
    assign o_AwAddr = Bus.Addr;
    assign o_ArAddr = Bus.Addr;
    assign o_WData  = Bus.WrData;
    assign o_WStrb  = Bus.WrStrb;

    // Channel finished already or handshaking now
    assign AwFinish = !o_AwValid || i_AwReady;
    assign WFinish  = !o_WValid || i_WReady;

    // ----------------------------------------------------------
    // Channel sequencing
    // ----------------------------------------------------------

    always_ff @(posedge i_Clock or negedge i_rstN) begin
        if (!i_rstN) begin
            o_AwValid <= 1'b0;
            o_WValid  <= 1'b0;
            o_BReady  <= 1'b0;
            o_ArValid <= 1'b0;
            o_RReady  <= 1'b0;
            Bus.Done  <= 1'b0;
        end else begin
            Bus.Done <= 1'b0;

            // Address and data raised together for a write request
            if (Bus.Req) begin
                if (Bus.WrEnable) begin
                    o_AwValid <= 1'b1;
                    o_WValid  <= 1'b1;
                end else begin
                    o_ArValid <= 1'b1;
                end
            end

            // Each write channel drops on its own ready
            if (o_AwValid && i_AwReady) begin
                o_AwValid <= 1'b0;
            end
            if (o_WValid && i_WReady) begin
                o_WValid <= 1'b0;
            end

            // Response awaited once both write channels are through
            if ((o_AwValid || o_WValid) && AwFinish && WFinish) begin
                o_BReady <= 1'b1;
            end
            if (o_BReady && i_BValid) begin
                o_BReady <= 1'b0;
                Bus.Done <= 1'b1;
            end

            // Read data follows the read address
            if (o_ArValid && i_ArReady) begin
                o_ArValid <= 1'b0;
                o_RReady  <= 1'b1;
            end
            if (o_RReady && i_RValid) begin
                o_RReady <= 1'b0;
                Bus.Done <= 1'b1;
            end
        end
    end

    // Read word kept for the Done cycle and after
    always_ff @(posedge i_Clock) begin
        if (o_RReady && i_RValid) begin
            Bus.RdData <= i_RData;
        end
    end

    // ----------------------------------------------------------
    // AXI4-Lite source rules
    // ----------------------------------------------------------

    // Requests only reach an idle adapter
    assert property (@(posedge i_Clock) disable iff (!i_rstN)
        Bus.Req |-> !(o_AwValid || o_WValid || o_BReady || o_ArValid || o_RReady));

    // Datapath must not move the address under a pending valid
    assert property (@(posedge i_Clock) disable iff (!i_rstN)
        (o_AwValid && !i_AwReady) || (o_ArValid && !i_ArReady) |=> $stable(Bus.Addr));

    // Write data and strobes held while WValid waits
    assert property (@(posedge i_Clock) disable iff (!i_rstN)
        o_WValid && !i_WReady |=> $stable(Bus.WrData) && $stable(Bus.WrStrb));

endmodule

`default_nettype wire

// ==== hdl/StageMEM.sv ====
`timescale 1ns/1ns
`default_nettype none

module StageMEM import MemStagePkg::*; (
    input  logic                  i_Clock,
    input  logic                  i_rstN,
    input  logic                  i_Hold,          // Capture strobe from the sequencer
    input  logic [PC_WIDTH-1:0]   i_Pc,
    input  logic [DATA_WIDTH-1:0] i_Result,
    input  logic [DATA_WIDTH-1:0] i_DataB,
    input  logic                  i_MemWrEnable,
    input  MemSize_t              i_MemSize,
    input  RegWrSel_t             i_RegWrDataSel,  // Already held by the sequencer
    input  logic                  i_WbLoad,
    DataMemoryBus.Master          DBus,
    output logic [DATA_WIDTH-1:0] o_RegWrData
);

    logic [PC_WIDTH-1:0]   HoldPc;
    logic [DATA_WIDTH-1:0] HoldResult;
    logic [DATA_WIDTH-1:0] HoldDataB;
    logic                  HoldMemWrEnable;
    MemSize_t              HoldMemSize;
    logic [PC_WIDTH-1:0]   PcPlus4;
    logic [DATA_WIDTH-1:0] LoadData;
    logic [DATA_WIDTH-1:0] WbSource;

    // ----------------------------------------------------------
    // Execute fields, held for the whole access
    // ----------------------------------------------------------

    always_ff @(posedge i_Clock or negedge i_rstN) begin
        if (!i_rstN) begin
            HoldMemWrEnable <= 1'b0;
        end else if (i_Hold) begin
            HoldMemWrEnable <= i_MemWrEnable;
        end
    end

    always_ff @(posedge i_Clock) begin
        if (i_Hold) begin
            HoldPc      <= i_Pc;
            HoldResult  <= i_Result;
            HoldDataB   <= i_DataB;
            HoldMemSize <= i_MemSize;
        end
    end

    // Bus address is the ALU result
    assign DBus.Addr     = HoldResult[ADDR_WIDTH-1:0];
    assign DBus.WrEnable = HoldMemWrEnable;

    // Lane placement for stores, lane extraction for loads
    LoadStoreAligner Aligner (
        .i_Addr      (HoldResult[1:0]),
        .i_MemSize   (HoldMemSize),
        .i_StoreData (HoldDataB),
        .i_RdWord    (DBus.RdData),
        .o_WrData    (DBus.WrData),
        .o_WrStrb    (DBus.WrStrb),
        .o_LoadData  (LoadData));

    // ----------------------------------------------------------
    // Write-back source
    // ----------------------------------------------------------

    // Link value for jal and jalr
    assign PcPlus4 = HoldPc + PC_WIDTH'(4);

    always_comb begin
        case (i_RegWrDataSel)
            SelAlu:     WbSource = HoldResult;
            SelMemData: WbSource = LoadData;
            SelPcPlus4: WbSource = DATA_WIDTH'(PcPlus4);
            default:    WbSource = HoldResult;
        endcase
    end

    // Write-back register, loaded once per instruction
    always_ff @(posedge i_Clock) begin
        if (i_WbLoad) begin
            o_RegWrData <= WbSource;
        end
    end

    // Sequencer never hands over the unused select code
    assert property (@(posedge i_Clock) disable iff (!i_rstN)
        i_WbLoad |-> i_RegWrDataSel != RegWrSel_t'(2'd3));

    // Misaligned accesses are excluded, checked where the request goes out
    assert property (@(posedge i_Clock) disable iff (!i_rstN)
        DBus.Req && (HoldMemSize inside {SizeHalf, SizeHalfU}) |-> !HoldResult[0]);
    assert property (@(posedge i_Clock) disable iff (!i_rstN)
        DBus.Req && HoldMemSize == SizeWord |-> HoldResult[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== hdl/LoadStoreAligner.sv ====
`timescale 1ns/1ns
`default_nettype none

module LoadStoreAligner import MemStagePkg::*; (
    input  logic [1:0]            i_Addr,       // Byte offset inside the word
    input  MemSize_t              i_MemSize,
    input  logic [DATA_WIDTH-1:0] i_StoreData,
    input  logic [DATA_WIDTH-1:0] i_RdWord,
    output logic [DATA_WIDTH-1:0] o_WrData,
    output logic [3:0]            o_WrStrb,
    output logic [DATA_WIDTH-1:0] o_LoadData
);

    MemWord_u   StoreWord;
    MemWord_u   RdWord;
    logic [7:0]  LaneByte;
    logic [15:0] LaneHalf;

    // ----------------------------------------------------------
    // Store side
    // ----------------------------------------------------------

    // Value copied into every lane, strobes pick the addressed ones
    always_comb begin
        StoreWord.Word = i_StoreData;
        o_WrStrb       = 4'b1111;
        case (i_MemSize)
            SizeByte, SizeByteU: begin
                StoreWord.Bytes = {4{i_StoreData[7:0]}};
                o_WrStrb        = 4'b0001 << i_Addr;
            end
            SizeHalf, SizeHalfU: begin
                StoreWord.Halves = {2{i_StoreData[15:0]}};
                o_WrStrb         = 4'b0011 << {i_Addr[1], 1'b0};
            end
            default: begin
                // Word store, all lanes as given
            end
        endcase
    end

    assign o_WrData = StoreWord.Word;

    // ----------------------------------------------------------
    // Load side
    // ----------------------------------------------------------

    assign RdWord.Word = i_RdWord;

    // Same word decoded by byte lane and by half lane
    assign LaneByte = RdWord.Bytes[i_Addr];
    assign LaneHalf = RdWord.Halves[i_Addr[1]];

    always_comb begin
        case (i_MemSize)
            SizeByte:  o_LoadData = {{(DATA_WIDTH-8){LaneByte[7]}}, LaneByte};
            SizeByteU: o_LoadData = {{(DATA_WIDTH-8){1'b0}}, LaneByte};
            SizeHalf:  o_LoadData = {{(DATA_WIDTH-16){LaneHalf[15]}}, LaneHalf};
            SizeHalfU: o_LoadData = {{(DATA_WIDTH-16){1'b0}}, LaneHalf};
            default:   o_LoadData = RdWord.Word;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/DataMemoryBus.sv ====
`timescale 1ns/1ns
`default_nettype none

interface DataMemoryBus import MemStagePkg::*; ();

    // Access description, held by the datapath until Done
    logic [ADDR_WIDTH-1:0] Addr;
    logic [DATA_WIDTH-1:0] WrData;
    logic [3:0]            WrStrb;
    logic                  WrEnable;

    // One-cycle start pulse from the sequencer
    logic                  Req;

    // One-cycle end pulse, read data valid with it
    logic                  Done;
    logic [DATA_WIDTH-1:0] RdData;

    // Datapath side
    modport Master (
        output Addr, WrData, WrStrb, WrEnable,
        input  Req, RdData);

    // Sequencer side, WrEnable tells a store apart
    modport Sequencer (
        output Req,
        input  WrEnable, Done);

    // AXI adapter side
    modport Slave (
        input  Addr, WrData, WrStrb, WrEnable, Req,
        output Done, RdData);

endinterface

`default_nettype wire

// ==== hdl/MemStagePkg.sv ====
`default_nettype none

package MemStagePkg;

    // ----------------------------------------------------------
    // Datapath widths
    // ----------------------------------------------------------

    localparam int DATA_WIDTH = 32;
    localparam int ADDR_WIDTH = 32;
    localparam int PC_WIDTH   = 32;
    localparam int REG_WIDTH  = 5;

    // ----------------------------------------------------------
    // Control encodings
    // ----------------------------------------------------------

    // Write-back source, encoding 3 is unused
    typedef enum logic [1:0] {
        SelAlu     = 2'd0,
        SelMemData = 2'd1,
        SelPcPlus4 = 2'd2
    } RegWrSel_t;

    // Access size, same code as funct3 of loads and stores
    typedef enum logic [2:0] {
        SizeByte  = 3'b000,
        SizeHalf  = 3'b001,
        SizeWord  = 3'b010,
        SizeByteU = 3'b100,
        SizeHalfU = 3'b101
    } MemSize_t;

    // One memory word, seen whole, by byte lane or by half lane
    typedef union packed {
        logic [DATA_WIDTH-1:0] Word;
        logic [3:0][7:0]       Bytes;
        logic [1:0][15:0]      Halves;
    } MemWord_u;

endpackage

`default_nettype wire
